// ==== logic/gcode_pkg.sv ====
package gcode_pkg;

	localparam int BYTE_BITS = 8; // one ASCII character
	localparam int DEFAULT_POS_BITS = 16; // signed coordinate width

	// classes of the characters the grammar knows about
	typedef enum logic [2:0] {
		CH_G,
		CH_X,
		CH_Y,
		CH_DIGIT,
		CH_MINUS,
		CH_SPACE,
		CH_NEWLINE,
		CH_OTHER
	} char_class_t;

	typedef enum logic [2:0] {
		CMD_RAPID, // G0
		CMD_LINEAR, // G1
		CMD_ABS, // G90
		CMD_REL, // G91
		CMD_UNKNOWN
	} cmd_t;

	typedef enum logic {
		OP_RAPID,
		OP_LINEAR
	} op_code_t;

	typedef enum logic [3:0] {
		ST_READ,
		ST_WAIT_CHAR,
		ST_ROUTE,
		ST_SKIP,
		ST_EXEC,
		ST_EXEC_WAIT,
		ST_WRITE,
		ST_WAIT_WRITE
	} fsm_state_t;

endpackage : gcode_pkg

// ==== logic/char_decoder.sv ====
module char_decoder (
	input logic [gcode_pkg::BYTE_BITS-1:0] ch,
	output gcode_pkg::char_class_t char_class,
	output logic [3:0] digit
);
	import gcode_pkg::*;

	// only meaningful when the class is CH_DIGIT
	assign digit = 4'(ch - 8'h30);

	always_comb begin
		case (ch)
			8'h47: char_class = CH_G; // 'G'
			8'h58: char_class = CH_X; // 'X'
			8'h59: char_class = CH_Y; // 'Y'
			8'h2d: char_class = CH_MINUS;
			8'h20: char_class = CH_SPACE;
			8'h0a: char_class = CH_NEWLINE;
			default: begin
				if (ch >= 8'h30 && ch <= 8'h39) begin
					char_class = CH_DIGIT;
				end
				else begin
					char_class = CH_OTHER;
				end
			end
		endcase
	end

endmodule : char_decoder

// ==== logic/cmd_parser.sv ====
module cmd_parser (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input logic cmd_start,
	input logic cmd_char,
	input logic [3:0] digit,
	output gcode_pkg::cmd_t cmd
);
	import gcode_pkg::*;

	logic [6:0] num; // at most two digits are kept
	logic [1:0] count; // saturates at 3, meaning too many digits

	always_ff @(posedge clk) begin
		if (reset) begin
			num <= '0;
			count <= '0;
		end
		else if (clk_en) begin
			if (cmd_start) begin
				num <= '0;
				count <= '0;
			end
			else if (cmd_char) begin
				if (count < 2'd2) begin
					num <= 7'(num * 7'd10 + {3'b000, digit});
				end
				if (count != 2'd3) begin
					count <= count + 2'd1;
				end
			end
		end
	end

	always_comb begin
		cmd = CMD_UNKNOWN;
		if (count == 2'd1 || count == 2'd2) begin
			case (num)
				7'd0: cmd = CMD_RAPID;
				7'd1: cmd = CMD_LINEAR;
				7'd90: cmd = CMD_ABS;
				7'd91: cmd = CMD_REL;
				default: cmd = CMD_UNKNOWN;
			endcase
		end
	end

	// the FSM strobes exactly one of these per character
	a_start_char_excl: assert property (@(posedge clk) disable iff (reset)
		!(cmd_start && cmd_char));

endmodule : cmd_parser

// ==== logic/arg_parser.sv ====
module arg_parser #(
	parameter int POS_BITS = 16
) (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input logic arg_start,
	input logic arg_char,
	input gcode_pkg::char_class_t char_class,
	input logic [3:0] digit,
	output logic signed [POS_BITS-1:0] arg_x,
	output logic signed [POS_BITS-1:0] arg_y,
	output logic has_x,
	output logic has_y,
	output logic arg_error
);
	import gcode_pkg::*;

	logic axis_open; // an X or Y word is being read
	logic axis_is_y;
	logic neg;
	logic got_digit;
	logic [POS_BITS-1:0] value; // magnitude, wraps like the coordinates
	logic signed [POS_BITS-1:0] word_val;

	assign word_val = neg ? -$signed(value) : $signed(value);

	always_ff @(posedge clk) begin
		if (reset) begin
			axis_open <= 1'b0;
			has_x <= 1'b0;
			has_y <= 1'b0;
			arg_error <= 1'b0;
		end
		else if (clk_en) begin
			if (arg_start) begin
				axis_open <= 1'b0;
				has_x <= 1'b0;
				has_y <= 1'b0;
				arg_error <= 1'b0;
			end
			else if (arg_char) begin
				case (char_class)
					CH_X, CH_Y: begin
						if (axis_open) begin
							arg_error <= 1'b1; // words must be separated by a space
						end
						axis_open <= 1'b1;
						axis_is_y <= (char_class == CH_Y);
						neg <= 1'b0;
						got_digit <= 1'b0;
						value <= '0;
					end
					CH_DIGIT: begin
						if (!axis_open) begin
							arg_error <= 1'b1;
						end
						value <= value * POS_BITS'(10) + POS_BITS'(digit);
						got_digit <= 1'b1;
					end
					CH_MINUS: begin
						if (!axis_open || neg || got_digit) begin
							arg_error <= 1'b1;
						end
						neg <= 1'b1;
					end
					CH_SPACE, CH_NEWLINE: begin
						if (axis_open) begin
							axis_open <= 1'b0;
							if (!got_digit) begin
								arg_error <= 1'b1;
							end
							else if (axis_is_y) begin
								arg_y <= word_val;
								has_y <= 1'b1;
							end
							else begin
								arg_x <= word_val;
								has_x <= 1'b1;
							end
						end
					end
					default: arg_error <= 1'b1; // G or anything unknown
				endcase
			end
		end
	end

	a_start_char_excl: assert property (@(posedge clk) disable iff (reset)
		!(arg_start && arg_char));

endmodule : arg_parser

// ==== logic/position_keeper.sv ====
module position_keeper #(
	parameter int POS_BITS = 16
) (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input logic exec,
	input gcode_pkg::cmd_t cmd,
	input logic signed [POS_BITS-1:0] arg_x,
	input logic signed [POS_BITS-1:0] arg_y,
	input logic has_x,
	input logic has_y,
	output logic emit,
	output gcode_pkg::op_code_t op_code,
	output logic signed [POS_BITS-1:0] op_x,
	output logic signed [POS_BITS-1:0] op_y
);
	import gcode_pkg::*;

	logic rel_mode; // set by G91, cleared by G90
	logic signed [POS_BITS-1:0] pos_x;
	logic signed [POS_BITS-1:0] pos_y;
	logic signed [POS_BITS-1:0] tgt_x;
	logic signed [POS_BITS-1:0] tgt_y;
	logic is_move;

	function automatic logic signed [POS_BITS-1:0] axis_target(
		input logic signed [POS_BITS-1:0] pos,
		input logic signed [POS_BITS-1:0] arg,
		input logic present,
		input logic rel
	);
		logic signed [POS_BITS-1:0] delta;
		delta = present ? arg : '0;
		if (rel) begin
			return pos + delta; // wraps at POS_BITS
		end
		return present ? arg : pos;
	endfunction

	assign tgt_x = axis_target(pos_x, arg_x, has_x, rel_mode);
	assign tgt_y = axis_target(pos_y, arg_y, has_y, rel_mode);
	assign is_move = (cmd == CMD_RAPID) || (cmd == CMD_LINEAR);

	always_ff @(posedge clk) begin
		if (reset) begin
			rel_mode <= 1'b0;
			pos_x <= '0;
			pos_y <= '0;
			emit <= 1'b0;
		end
		else if (clk_en) begin
			emit <= exec && is_move;
			if (exec) begin
				if (cmd == CMD_ABS) begin
					rel_mode <= 1'b0;
				end
				else if (cmd == CMD_REL) begin
					rel_mode <= 1'b1;
				end
				else if (is_move) begin
					pos_x <= tgt_x;
					pos_y <= tgt_y;
					op_x <= tgt_x;
					op_y <= tgt_y;
					op_code <= (cmd == CMD_RAPID) ? OP_RAPID : OP_LINEAR;
				end
			end
		end
	end

	// bad commands are turned into parse_error by the FSM before execution
	a_no_unknown_exec: assert property (@(posedge clk) disable iff (reset)
		exec |-> cmd != CMD_UNKNOWN);

endmodule : position_keeper

// ==== logic/parser_fsm.sv ====
module parser_fsm (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input logic rd_done,
	input logic rd_rdy,
	input logic is_empty,
	input logic wr_done,
	input logic wr_rdy,
	input logic is_full,
	input gcode_pkg::char_class_t char_class,
	input gcode_pkg::cmd_t cmd,
	input logic arg_error,
	input logic emit,
	output logic store,
	output logic rd_trigger,
	output logic wr_trigger,
	output logic cmd_start,
	output logic cmd_char,
	output logic arg_start,
	output logic arg_char,
	output logic exec,
	output logic parse_error
);
	import gcode_pkg::*;

	fsm_state_t state, state_next;
	logic in_cmd, in_cmd_next; // G seen, command number still open
	logic in_args, in_args_next;
	logic skip, skip_next; // dropping a bad line up to its newline
	logic rd_pending; // read issued, rd_done not yet seen

	always_comb begin
		state_next = state;
		in_cmd_next = in_cmd;
		in_args_next = in_args;
		skip_next = skip;
		store = 1'b0;
		rd_trigger = 1'b0;
		wr_trigger = 1'b0;
		cmd_start = 1'b0;
		cmd_char = 1'b0;
		arg_start = 1'b0;
		arg_char = 1'b0;
		exec = 1'b0;
		parse_error = 1'b0;
		if (clk_en) begin
			case (state)
				ST_READ: begin
					if (rd_rdy && !is_empty) begin
						rd_trigger = 1'b1;
						state_next = ST_WAIT_CHAR;
					end
				end
				ST_WAIT_CHAR: begin
					if (rd_done) begin
						store = 1'b1;
						state_next = skip ? ST_SKIP : ST_ROUTE;
					end
				end
				ST_SKIP: begin
					state_next = ST_READ;
					if (char_class == CH_NEWLINE) begin
						parse_error = 1'b1;
						skip_next = 1'b0;
					end
				end
				ST_ROUTE: begin
					state_next = ST_READ;
					if (in_args) begin
						arg_char = 1'b1;
						if (char_class == CH_NEWLINE) begin
							in_args_next = 1'b0;
							state_next = ST_EXEC;
						end
					end
					else if (in_cmd) begin
						in_cmd_next = 1'b0;
						case (char_class)
							CH_DIGIT: begin
								cmd_char = 1'b1;
								in_cmd_next = 1'b1;
							end
							CH_SPACE: begin
								arg_start = 1'b1;
								in_args_next = 1'b1;
							end
							CH_NEWLINE: begin
								arg_start = 1'b1; // line ends right after the command
								state_next = ST_EXEC;
							end
							default: skip_next = 1'b1;
						endcase
					end
					else if (char_class == CH_G) begin
						cmd_start = 1'b1;
						in_cmd_next = 1'b1;
					end
					else if (char_class == CH_NEWLINE) begin
						parse_error = 1'b1; // empty line
					end
					else begin
						skip_next = 1'b1;
					end
				end
				ST_EXEC: begin
					if (arg_error || cmd == CMD_UNKNOWN) begin
						parse_error = 1'b1;
						state_next = ST_READ;
					end
					else begin
						exec = 1'b1;
						state_next = ST_EXEC_WAIT;
					end
				end
				ST_EXEC_WAIT: state_next = emit ? ST_WRITE : ST_READ; // G90/G91 write nothing
				ST_WRITE: begin
					if (wr_rdy && !is_full) begin
						wr_trigger = 1'b1;
						state_next = ST_WAIT_WRITE;
					end
				end
				ST_WAIT_WRITE: begin
					if (wr_done) begin
						state_next = ST_READ;
					end
				end
				default: state_next = ST_READ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_READ;
			in_cmd <= 1'b0;
			in_args <= 1'b0;
			skip <= 1'b0;
			rd_pending <= 1'b0;
		end
		else if (clk_en) begin
			state <= state_next;
			in_cmd <= in_cmd_next;
			in_args <= in_args_next;
			skip <= skip_next;
			if (rd_trigger) begin
				rd_pending <= 1'b1;
			end
			else if (rd_done) begin
				rd_pending <= 1'b0;
			end
		end
	end

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
		!(rd_trigger && wr_trigger));

	// one read in flight at a time
	a_single_read: assert property (@(posedge clk) disable iff (reset)
		!(rd_trigger && rd_pending));

endmodule : parser_fsm

// ==== logic/parser_top.sv ====
module parser_top #(
	parameter int POS_BITS = gcode_pkg::DEFAULT_POS_BITS
) (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input logic rd_done,
	input logic rd_rdy,
	input logic is_empty,
	input logic [gcode_pkg::BYTE_BITS-1:0] char_in,
	input logic wr_done,
	input logic wr_rdy,
	input logic is_full,
	output logic rd_trigger,
	output logic wr_trigger,
	output gcode_pkg::op_code_t op_code,
	output logic signed [POS_BITS-1:0] op_x,
	output logic signed [POS_BITS-1:0] op_y,
	output logic parse_error
);
	import gcode_pkg::*;

	logic [BYTE_BITS-1:0] stored_char;
	char_class_t char_class;
	logic [3:0] digit;
	cmd_t cmd;
	logic store, cmd_start, cmd_char, arg_start, arg_char, exec, emit;
	logic signed [POS_BITS-1:0] arg_x;
	logic signed [POS_BITS-1:0] arg_y;
	logic has_x, has_y, arg_error;

	always_ff @(posedge clk) begin
		if (clk_en && store) begin
			stored_char <= char_in; // captured in the rd_done cycle
		end
	end

	char_decoder u_char_decoder (.ch(stored_char), .char_class(char_class), .digit(digit));

	cmd_parser u_cmd_parser (
		.clk(clk), .reset(reset), .clk_en(clk_en),
		.cmd_start(cmd_start), .cmd_char(cmd_char), .digit(digit), .cmd(cmd)
	);

	arg_parser #(.POS_BITS(POS_BITS)) u_arg_parser (
		.clk(clk), .reset(reset), .clk_en(clk_en),
		.arg_start(arg_start), .arg_char(arg_char), .char_class(char_class), .digit(digit),
		.arg_x(arg_x), .arg_y(arg_y), .has_x(has_x), .has_y(has_y), .arg_error(arg_error)
	);

	position_keeper #(.POS_BITS(POS_BITS)) u_position_keeper (
		.clk(clk), .reset(reset), .clk_en(clk_en), .exec(exec), .cmd(cmd),
		.arg_x(arg_x), .arg_y(arg_y), .has_x(has_x), .has_y(has_y),
		.emit(emit), .op_code(op_code), .op_x(op_x), .op_y(op_y)
	);

	parser_fsm u_parser_fsm (
		.clk(clk), .reset(reset), .clk_en(clk_en),
		.rd_done(rd_done), .rd_rdy(rd_rdy), .is_empty(is_empty),
		.wr_done(wr_done), .wr_rdy(wr_rdy), .is_full(is_full),
		.char_class(char_class), .cmd(cmd), .arg_error(arg_error), .emit(emit),
		.store(store), .rd_trigger(rd_trigger), .wr_trigger(wr_trigger),
		.cmd_start(cmd_start), .cmd_char(cmd_char), .arg_start(arg_start),
		.arg_char(arg_char), .exec(exec), .parse_error(parse_error)
	);

endmodule : parser_top

// ==== bench/parser_tb.sv ====
module parser_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import gcode_pkg::*;

	localparam int POS_BITS = DEFAULT_POS_BITS;
	localparam int TIMEOUT = 2000; // cycles allowed for each wait

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic clk_en;
	logic rd_done;
	logic rd_rdy;
	logic is_empty;
	logic [BYTE_BITS-1:0] char_in;
	logic wr_done;
	logic wr_rdy;
	logic is_full;
	logic rd_trigger;
	logic wr_trigger;
	logic parse_error;
	op_code_t op_code;
	logic signed [POS_BITS-1:0] op_x;
	logic signed [POS_BITS-1:0] op_y;

	// stall requests from the tests, applied on the next falling edge
	logic stall_en = 1'b0;
	logic force_empty = 1'b0;
	logic drop_rdy = 1'b0;
	logic force_full = 1'b0;
	logic drop_wr_rdy = 1'b0;

	byte char_queue[$]; // characters not yet handed to the parser
	op_code_t log_code[$];
	logic signed [POS_BITS-1:0] log_x[$];
	logic signed [POS_BITS-1:0] log_y[$];
	integer seed = 25917;
	logic rd_busy = 1'b0;
	logic wr_busy = 1'b0;
	int rd_wait = 0;
	int wr_wait = 0;
	int delivered = 0;
	int rd_count = 0;
	int wr_count = 0;
	int pe_count = 0;
	int pe_expected = 0;
	int errors = 0;
	int timeouts = 0;
	logic signed [POS_BITS-1:0] model_x = '0; // reference machine position
	logic signed [POS_BITS-1:0] model_y = '0;
	logic model_rel = 1'b0;

	parser_top #(.POS_BITS(POS_BITS)) UUT (
		.clk(clk), .reset(reset), .clk_en(clk_en),
		.rd_done(rd_done), .rd_rdy(rd_rdy), .is_empty(is_empty), .char_in(char_in),
		.wr_done(wr_done), .wr_rdy(wr_rdy), .is_full(is_full),
		.rd_trigger(rd_trigger), .wr_trigger(wr_trigger),
		.op_code(op_code), .op_x(op_x), .op_y(op_y), .parse_error(parse_error)
	);

	always #5 clk = ~clk;

	// reader and writer models, driven on the falling edge
	initial begin
		clk_en = 1'b1;
		rd_done = 1'b0;
		rd_rdy = 1'b1;
		is_empty = 1'b1;
		char_in = '0;
		wr_done = 1'b0;
		wr_rdy = 1'b1;
		is_full = 1'b0;
		forever begin
			@(negedge clk);
			clk_en = !stall_en;
			rd_done = 1'b0;
			wr_done = 1'b0;
			if (clk_en && rd_busy) begin
				rd_wait--;
				if (rd_wait == 0 && char_queue.size() > 0) begin
					rd_busy = 1'b0;
					rd_done = 1'b1;
					char_in = char_queue.pop_front();
					delivered++;
				end
			end
			if (clk_en && wr_busy) begin
				wr_wait--;
				if (wr_wait == 0) begin
					wr_busy = 1'b0;
					wr_done = 1'b1;
				end
			end
			rd_rdy = !drop_rdy;
			is_empty = force_empty || (char_queue.size() == 0);
			wr_rdy = !drop_wr_rdy;
			is_full = force_full;
			#1; // outputs settle well before the rising edge
			if (!reset) begin
				if (rd_trigger) begin
					if (rd_busy) begin
						errors++;
						$display("a read was issued while another read was outstanding");
					end
					rd_count++;
					rd_busy = 1'b1;
					rd_wait = 1 + ({$random(seed)} % 4);
				end
				if (wr_trigger) begin
					wr_count++;
					log_code.push_back(op_code);
					log_x.push_back(op_x);
					log_y.push_back(op_y);
					wr_busy = 1'b1;
					wr_wait = 1 + ({$random(seed)} % 3);
				end
				if (parse_error) begin
					pe_count++;
				end
			end
		end
	end

	task automatic report_mismatch(input string name, input string what, input int exp,
			input int act);
		errors++;
		$display("FAIL %s: %s expected %0d, actual %0d", name, what, exp, act);
	endtask

	task automatic send_line(input string line);
		for (int i = 0; i < line.len(); i++) begin
			char_queue.push_back(line[i]);
		end
		char_queue.push_back(8'h0a);
	endtask

	task automatic wait_op(input string name);
		int waited;
		waited = 0;
		while (log_code.size() == 0 && waited < TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (log_code.size() == 0) begin
			errors++;
			timeouts++;
			$display("%s: timed out waiting for an op to be written", name);
		end
	endtask

	task automatic wait_delivered(input string name, input int target);
		int waited;
		waited = 0;
		while (delivered < target && waited < TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (delivered < target) begin
			errors++;
			timeouts++;
			$display("%s: timed out waiting for the reader to hand over characters", name);
		end
	endtask

	// no read or write may start during the window
	task automatic watch_idle(input string name, input int cycles);
		int rd_base;
		int wr_base;
		rd_base = rd_count;
		wr_base = wr_count;
		repeat (cycles) @(posedge clk);
		if (rd_count != rd_base) report_mismatch(name, "rd_trigger pulses", rd_base, rd_count);
		if (wr_count != wr_base) report_mismatch(name, "wr_trigger pulses", wr_base, wr_count);
	endtask

	task automatic expect_move(input string name, input op_code_t code, input logic hx,
			input int x, input logic hy, input int y);
		logic signed [POS_BITS-1:0] ex;
		logic signed [POS_BITS-1:0] ey;
		op_code_t got_code;
		logic signed [POS_BITS-1:0] got_x;
		logic signed [POS_BITS-1:0] got_y;
		if (model_rel) begin
			ex = model_x + (hx ? POS_BITS'(x) : POS_BITS'(0)); // wraps at 16 bits
			ey = model_y + (hy ? POS_BITS'(y) : POS_BITS'(0));
		end
		else begin
			ex = hx ? POS_BITS'(x) : model_x;
			ey = hy ? POS_BITS'(y) : model_y;
		end
		model_x = ex;
		model_y = ey;
		wait_op(name);
		if (log_code.size() > 0) begin
			got_code = log_code.pop_front();
			got_x = log_x.pop_front();
			got_y = log_y.pop_front();
			if (got_code != code) report_mismatch(name, "op_code", int'(code), int'(got_code));
			if (got_x != ex) report_mismatch(name, "op_x", int'(ex), int'(got_x));
			if (got_y != ey) report_mismatch(name, "op_y", int'(ey), int'(got_y));
		end
		if (pe_count != pe_expected) begin
			report_mismatch(name, "parse_error pulses", pe_expected, pe_count);
			pe_count = pe_expected; // keep later tests independent
		end
	endtask

	task automatic run_move(input string name, input string line, input op_code_t code,
			input logic hx, input int x, input logic hy, input int y);
		send_line(line);
		expect_move(name, code, hx, x, hy, y);
	endtask

	task automatic set_mode(input logic rel);
		send_line(rel ? "G91" : "G90");
		model_rel = rel;
	endtask

	task automatic absolute_moves();
		run_move("abs_g1", "G1 X120 Y-35", OP_LINEAR, 1'b1, 120, 1'b1, -35);
		run_move("abs_g0_x", "G0 X7", OP_RAPID, 1'b1, 7, 1'b0, 0);
		run_move("abs_g1_y", "G1 Y-2048", OP_LINEAR, 1'b0, 0, 1'b1, -2048);
	endtask

	task automatic mode_changes();
		set_mode(1'b1);
		run_move("rel_g1", "G1 X10 Y-5", OP_LINEAR, 1'b1, 10, 1'b1, -5);
		run_move("rel_wrap_1", "G0 X30000 Y-30000", OP_RAPID, 1'b1, 30000, 1'b1, -30000);
		run_move("rel_wrap_2", "G0 X30000 Y-30000", OP_RAPID, 1'b1, 30000, 1'b1, -30000);
		run_move("rel_no_args", "G1", OP_LINEAR, 1'b0, 0, 1'b0, 0);
		set_mode(1'b0);
		run_move("abs_again", "G0 X0 Y0", OP_RAPID, 1'b1, 0, 1'b1, 0);
	endtask

	// each bad line is followed by a good one that shows the position held
	task automatic bad_lines();
		send_line("G5");
		pe_expected++;
		run_move("after_g5", "G1 X3", OP_LINEAR, 1'b1, 3, 1'b0, 0);
		send_line("G1 X-");
		pe_expected++;
		run_move("after_bare_minus", "G0 Y4", OP_RAPID, 1'b0, 0, 1'b1, 4);
		send_line("G1 Q3");
		pe_expected++;
		run_move("after_bad_letter", "G1 X-9", OP_LINEAR, 1'b1, -9, 1'b0, 0);
		send_line("X5 Y5");
		pe_expected++;
		run_move("after_no_g", "G0 Y-6", OP_RAPID, 1'b0, 0, 1'b1, -6);
	endtask

	task automatic write_backpressure();
		int dl_base;
		dl_base = delivered;
		force_full = 1'b1;
		send_line("G1 X1 Y2");
		send_line("G0 Y9");
		wait_delivered("full_hold", dl_base + 9);
		watch_idle("full_hold", 20);
		force_full = 1'b0;
		drop_wr_rdy = 1'b1; // writer not ready although it has room
		watch_idle("wr_rdy_hold", 10);
		drop_wr_rdy = 1'b0;
		expect_move("full_first", OP_LINEAR, 1'b1, 1, 1'b1, 2);
		expect_move("full_second", OP_RAPID, 1'b0, 0, 1'b1, 9);
	endtask

	task automatic read_and_enable_stalls();
		int dl_base;
		force_empty = 1'b1;
		send_line("G1 X-300 Y44");
		watch_idle("empty_hold", 10);
		force_empty = 1'b0;
		drop_rdy = 1'b1;
		watch_idle("rdy_hold", 10);
		drop_rdy = 1'b0;
		expect_move("after_read_stall", OP_LINEAR, 1'b1, -300, 1'b1, 44);
		dl_base = delivered;
		send_line("G0 X-1 Y-1");
		wait_delivered("enable_hold", dl_base + 4);
		stall_en = 1'b1; // freeze mid-line
		watch_idle("enable_hold", 15);
		stall_en = 1'b0;
		expect_move("after_enable_stall", OP_RAPID, 1'b1, -1, 1'b1, -1);
	endtask

	initial begin
		repeat (8) @(negedge clk);
		reset = 1'b0;
		@(posedge clk);
		absolute_moves();
		mode_changes();
		bad_lines();
		write_backpressure();
		read_and_enable_stalls();
		if (log_code.size() != 0) begin
			errors++;
			$display("%0d ops were written that no line asked for", log_code.size());
		end
		$display("errors: %0d, timeouts: %0d, ops written: %0d, parse errors: %0d",
			errors, timeouts, wr_count, pe_count);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end
		else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule : parser_tb

// ==== all.f ====
logic/gcode_pkg.sv
logic/char_decoder.sv
logic/cmd_parser.sv
logic/arg_parser.sv
logic/position_keeper.sv
logic/parser_fsm.sv
logic/parser_top.sv
bench/parser_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module parser_tb -Mdir obj_dir -o parser_sim -f all.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/parser_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "SIMULATION PASSED" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
